/* logic/dma_pkg.sv */
package dma_pkg;

  // cluster size
  localparam int core_count    = 16;
  localparam int slot_count    = 16;
  localparam int port_count    = 2;
  localparam int core_no_width = $clog2(core_count);
  localparam int slot_no_width = $clog2(slot_count);

  // free slot descriptor, core number above slot number
  localparam int desc_width = core_no_width + slot_no_width;

  // address map of the cluster
  localparam int core_addr_width = 16;
  localparam int addr_width      = core_no_width + core_addr_width;

  // slot base addresses are aligned, only the middle bits are stored
  localparam int slot_lead_zero = 8;
  localparam int slot_addr_eff  = 7;
  localparam int slot_pad_width = core_addr_width - slot_addr_eff - slot_lead_zero;

  // receive data lands past the slot header
  localparam logic [slot_lead_zero-1:0] rx_write_offset = 8'h0A;

  localparam int                   len_width       = 16;
  localparam logic [len_width-1:0] def_max_pkt_len = 16'd2048;

  // room for every slot of every core
  localparam int desc_fifo_addr_width = $clog2(core_count * slot_count);

  localparam int pend_cnt_width = 10;

  // core message layout
  localparam int msg_width    = 64;
  localparam int msg_len_lsb  = 0;
  // out port byte is 23:16, upper bits reserved
  localparam int msg_port_lsb = 16;
  localparam int msg_slot_lsb = 24;
  localparam int msg_addr_lsb = 32;

endpackage

/* logic/rx_arb_if.sv */
interface rx_arb_if import dma_pkg::*; ();

  // looked-up descriptor waiting and not dropped
  logic                  offer;
  // mac rx ready per port
  logic [port_count-1:0] port_ready;
  // receive valid, at most one bit high
  logic [port_count-1:0] grant;
  logic                  sel;

  modport dispatch (
    output offer,
    output port_ready,
    input  grant,
    input  sel
  );

  modport arbiter (
    input  offer,
    input  port_ready,
    output grant,
    output sel
  );

endinterface

/* logic/desc_fifo.sv */
module desc_fifo import dma_pkg::*; #(
  parameter int depth_log2 = desc_fifo_addr_width,
  parameter int data_width = desc_width
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  push,
  input  logic [data_width-1:0] push_data,
  output logic                  full,
  input  logic                  pop,
  output logic [data_width-1:0] head,
  output logic                  head_valid
);

  logic [data_width-1:0] mem [0:(1<<depth_log2)-1];
  // extra msb tells full from empty
  logic [depth_log2:0]   wr_ptr;
  logic [depth_log2:0]   rd_ptr;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr[depth_log2-1:0]] <= push_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // show-ahead, head word is readable without a pop
  assign head       = mem[rd_ptr[depth_log2-1:0]];
  assign head_valid = (wr_ptr != rd_ptr);
  assign full       = (wr_ptr[depth_log2] != rd_ptr[depth_log2]) &&
                      (wr_ptr[depth_log2-1:0] == rd_ptr[depth_log2-1:0]);

  a_no_overflow: assert property (@(posedge clk) disable iff (rst) !(push && full))
    else $error("descriptor fifo pushed while full");

  a_no_underflow: assert property (@(posedge clk) disable iff (rst) !(pop && !head_valid))
    else $error("descriptor fifo popped while empty");

endmodule

/* logic/rx_desc_dispatch.sv */
module rx_desc_dispatch import dma_pkg::*; (
  input  logic                     clk,
  input  logic                     rst,
  input  logic [desc_width-1:0]    inject_desc,
  input  logic                     inject_desc_valid,
  output logic                     inject_desc_ready,
  input  logic [desc_width-1:0]    recycle_desc,
  input  logic                     recycle_valid,
  input  logic [core_count-1:0]    drop_list,
  input  logic                     drop_list_valid,
  input  logic [len_width-1:0]     max_pkt_len,
  input  logic                     max_pkt_len_valid,
  input  logic [slot_no_width-1:0] slot_addr_wr_no,
  input  logic [slot_addr_eff-1:0] slot_addr_wr_data,
  input  logic                     slot_addr_wr_valid,
  input  logic [port_count-1:0]    rx_desc_ready,
  output logic [addr_width-1:0]    rx_desc_addr,
  output logic [len_width-1:0]     rx_desc_len,
  rx_arb_if.dispatch               arb
);

  logic                     fifo_push;
  logic [desc_width-1:0]    fifo_push_data;
  logic                     fifo_full;
  logic                     fifo_pop;
  logic [desc_width-1:0]    fifo_head;
  logic                     fifo_head_valid;
  logic [core_no_width-1:0] head_core;
  logic [slot_no_width-1:0] head_slot;

  logic [core_count-1:0]    drop_list_r;
  logic [len_width-1:0]     max_pkt_len_r;
  logic [slot_addr_eff-1:0] slot_addr_mem [0:slot_count-1];

  logic                     desc_valid_r;
  logic [core_no_width-1:0] desc_core_r;
  logic [core_count-1:0]    desc_core_onehot_r;
  logic [slot_addr_eff-1:0] desc_slot_addr_r;
  logic                     drop;

  // recycled slots go first and injection waits a cycle
  assign inject_desc_ready = !recycle_valid && !fifo_full;
  assign fifo_push         = recycle_valid || (inject_desc_valid && inject_desc_ready);
  assign fifo_push_data    = recycle_valid ? recycle_desc : inject_desc;

  desc_fifo #(
    .depth_log2(desc_fifo_addr_width),
    .data_width(desc_width)
  ) u_desc_fifo (
    .clk       (clk),
    .rst       (rst),
    .push      (fifo_push),
    .push_data (fifo_push_data),
    .full      (fifo_full),
    .pop       (fifo_pop),
    .head      (fifo_head),
    .head_valid(fifo_head_valid)
  );

  assign head_core = fifo_head[desc_width-1 -: core_no_width];
  assign head_slot = fifo_head[slot_no_width-1:0];

  always_ff @(posedge clk) begin
    if (rst) begin
      drop_list_r   <= '0;
      max_pkt_len_r <= def_max_pkt_len;
    end else begin
      if (drop_list_valid) begin
        drop_list_r <= drop_list;
      end
      if (max_pkt_len_valid) begin
        max_pkt_len_r <= max_pkt_len;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (slot_addr_wr_valid) begin
      slot_addr_mem[slot_addr_wr_no] <= slot_addr_wr_data;
    end
  end

  // valid falls for one cycle after a pop so the next head can register
  always_ff @(posedge clk) begin
    if (rst) begin
      desc_valid_r <= 1'b0;
    end else begin
      desc_valid_r <= fifo_head_valid && !fifo_pop;
    end
  end

  always_ff @(posedge clk) begin
    desc_core_r        <= head_core;
    desc_core_onehot_r <= {{(core_count-1){1'b0}}, 1'b1} << head_core;
    desc_slot_addr_r   <= slot_addr_mem[head_slot];
  end

  assign drop           = |(desc_core_onehot_r & drop_list_r);
  assign arb.offer      = desc_valid_r && !drop;
  assign arb.port_ready = rx_desc_ready;

  // dropped descriptors leave without a valid
  assign fifo_pop = (desc_valid_r && drop) || (|arb.grant);

  assign rx_desc_addr = {desc_core_r, {slot_pad_width{1'b0}}, desc_slot_addr_r,
                         rx_write_offset};
  assign rx_desc_len  = max_pkt_len_r;

endmodule

/* logic/rx_port_arbiter.sv */
module rx_port_arbiter import dma_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [port_count-1:0] incoming_pkt_ready,
  rx_arb_if.arbiter             arb
);

  logic [pend_cnt_width-1:0] pend_cnt [port_count];
  logic [port_count-1:0]     pending;
  logic [port_count-1:0]     can_recv;
  logic                      last_sel;

  // packets that arrived but have no receive descriptor yet
  always_ff @(posedge clk) begin
    for (int p = 0; p < port_count; p++) begin
      if (rst) begin
        pend_cnt[p] <= '0;
      end else if (incoming_pkt_ready[p] && !arb.grant[p]) begin
        pend_cnt[p] <= pend_cnt[p] + 1'b1;
      end else if (arb.grant[p] && !incoming_pkt_ready[p]) begin
        pend_cnt[p] <= pend_cnt[p] - 1'b1;
      end
    end
  end

  always_comb begin
    for (int p = 0; p < port_count; p++) begin
      // a packet arriving this cycle counts as pending already
      pending[p]  = (pend_cnt[p] != '0) || incoming_pkt_ready[p];
      can_recv[p] = arb.offer && arb.port_ready[p] && pending[p];
    end
  end

  // the port that was not served last time goes first
  always_comb begin
    arb.sel = last_sel;
    if (last_sel && can_recv[0]) begin
      arb.sel = 1'b0;
    end else if (!last_sel && can_recv[1]) begin
      arb.sel = 1'b1;
    end
  end

  assign arb.grant[0] = can_recv[0] && !arb.sel;
  assign arb.grant[1] = can_recv[1] && arb.sel;

  always_ff @(posedge clk) begin
    if (rst) begin
      last_sel <= 1'b1;
    end else if (|arb.grant) begin
      last_sel <= arb.sel;
    end
  end

  a_grant_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(arb.grant))
    else $error("receive valid on both ports");

  for (genvar p = 0; p < port_count; p++) begin : g_cnt_chk
    a_cnt_no_wrap: assert property (@(posedge clk) disable iff (rst)
      (incoming_pkt_ready[p] && !arb.grant[p]) |-> (pend_cnt[p] != '1))
      else $error("pending packet counter overflow on port %0d", p);
  end

endmodule

/* logic/tx_desc_issue.sv */
module tx_desc_issue import dma_pkg::*; (
  input  logic                     clk,
  input  logic                     rst,
  input  logic [msg_width-1:0]     msg_data,
  input  logic [core_no_width-1:0] msg_core_no,
  input  logic                     msg_valid,
  output logic                     msg_ready,
  input  logic [port_count-1:0]    pkt_sent_out_valid,
  output logic [port_count-1:0]    tx_desc_valid,
  output logic [addr_width-1:0]    tx_desc_addr,
  output logic [len_width-1:0]     tx_desc_len,
  output logic [desc_width-1:0]    recycle_desc,
  output logic                     recycle_valid
);

  logic [len_width-1:0]       msg_len;
  logic                       msg_port;
  logic [slot_no_width-1:0]   msg_slot;
  logic [core_addr_width-1:0] msg_addr;
  logic [port_count-1:0]      port_free;
  logic                       accept;

  logic                       issue_r;
  logic                       issue_port_r;
  logic [slot_no_width-1:0]   issue_slot_r;
  logic [addr_width-1:0]      issue_addr_r;
  logic [len_width-1:0]       issue_len_r;

  logic [port_count-1:0]      busy;
  logic [desc_width-1:0]      sent_desc [port_count];

  assign msg_len  = msg_data[msg_len_lsb +: len_width];
  assign msg_port = msg_data[msg_port_lsb];
  assign msg_slot = msg_data[msg_slot_lsb +: slot_no_width];
  assign msg_addr = msg_data[msg_addr_lsb +: core_addr_width];

  // a port frees up in the cycle of its sent report
  assign port_free = ~busy | pkt_sent_out_valid;
  assign msg_ready = !issue_r && port_free[msg_port];
  assign accept    = msg_valid && msg_ready;

  // zero length means the core drops the packet, nothing is issued
  always_ff @(posedge clk) begin
    if (rst) begin
      issue_r <= 1'b0;
    end else begin
      issue_r <= accept && (msg_len != '0);
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      issue_port_r <= msg_port;
      issue_slot_r <= msg_slot;
      issue_addr_r <= {msg_core_no, msg_addr};
      issue_len_r  <= msg_len;
    end
  end

  assign tx_desc_valid[0] = issue_r && !issue_port_r;
  assign tx_desc_valid[1] = issue_r && issue_port_r;
  assign tx_desc_addr     = issue_addr_r;
  assign tx_desc_len      = issue_len_r;

  always_ff @(posedge clk) begin
    for (int p = 0; p < port_count; p++) begin
      if (rst) begin
        busy[p] <= 1'b0;
      end else if (tx_desc_valid[p]) begin
        busy[p] <= 1'b1;
      end else if (pkt_sent_out_valid[p]) begin
        busy[p] <= 1'b0;
      end
    end
  end

  // slot in flight on each port, returned to the free pool once sent
  always_ff @(posedge clk) begin
    for (int p = 0; p < port_count; p++) begin
      if (tx_desc_valid[p]) begin
        sent_desc[p] <= {issue_addr_r[addr_width-1 -: core_no_width], issue_slot_r};
      end
    end
  end

  assign recycle_valid = |pkt_sent_out_valid;
  assign recycle_desc  = pkt_sent_out_valid[1] ? sent_desc[1] : sent_desc[0];

  a_sent_when_busy: assert property (@(posedge clk) disable iff (rst)
    (pkt_sent_out_valid & ~busy) == '0)
    else $error("sent report on a port with no packet in flight");

endmodule

/* logic/dma_controller.sv */
module dma_controller import dma_pkg::*; (
  input  logic                     clk,
  input  logic                     rst,

  // mac events
  input  logic [port_count-1:0]    incoming_pkt_ready,
  input  logic [port_count-1:0]    pkt_sent_out_valid,

  // configuration
  input  logic [core_count-1:0]    drop_list,
  input  logic                     drop_list_valid,
  input  logic [len_width-1:0]     max_pkt_len,
  input  logic                     max_pkt_len_valid,
  input  logic [desc_width-1:0]    inject_desc,
  input  logic                     inject_desc_valid,
  output logic                     inject_desc_ready,
  input  logic [slot_no_width-1:0] slot_addr_wr_no,
  input  logic [slot_addr_eff-1:0] slot_addr_wr_data,
  input  logic                     slot_addr_wr_valid,

  // receive descriptors, address and length shared by both ports
  input  logic [port_count-1:0]    rx_desc_ready,
  output logic [port_count-1:0]    rx_desc_valid,
  output logic [addr_width-1:0]    rx_desc_addr,
  output logic [len_width-1:0]     rx_desc_len,

  // core messages
  input  logic [msg_width-1:0]     msg_data,
  input  logic [core_no_width-1:0] msg_core_no,
  input  logic                     msg_valid,
  output logic                     msg_ready,

  // transmit descriptors
  // ready is not needed, a port is released by its sent report
  input  logic [port_count-1:0]    tx_desc_ready,
  output logic [port_count-1:0]    tx_desc_valid,
  output logic [addr_width-1:0]    tx_desc_addr,
  output logic [len_width-1:0]     tx_desc_len
);

  logic [desc_width-1:0] recycle_desc;
  logic                  recycle_valid;

  rx_arb_if arb ();

  rx_desc_dispatch u_rx_desc_dispatch (
    .clk               (clk),
    .rst               (rst),
    .inject_desc       (inject_desc),
    .inject_desc_valid (inject_desc_valid),
    .inject_desc_ready (inject_desc_ready),
    .recycle_desc      (recycle_desc),
    .recycle_valid     (recycle_valid),
    .drop_list         (drop_list),
    .drop_list_valid   (drop_list_valid),
    .max_pkt_len       (max_pkt_len),
    .max_pkt_len_valid (max_pkt_len_valid),
    .slot_addr_wr_no   (slot_addr_wr_no),
    .slot_addr_wr_data (slot_addr_wr_data),
    .slot_addr_wr_valid(slot_addr_wr_valid),
    .rx_desc_ready     (rx_desc_ready),
    .rx_desc_addr      (rx_desc_addr),
    .rx_desc_len       (rx_desc_len),
    .arb               (arb.dispatch)
  );

  rx_port_arbiter u_rx_port_arbiter (
    .clk               (clk),
    .rst               (rst),
    .incoming_pkt_ready(incoming_pkt_ready),
    .arb               (arb.arbiter)
  );

  assign rx_desc_valid = arb.grant;

  tx_desc_issue u_tx_desc_issue (
    .clk               (clk),
    .rst               (rst),
    .msg_data          (msg_data),
    .msg_core_no       (msg_core_no),
    .msg_valid         (msg_valid),
    .msg_ready         (msg_ready),
    .pkt_sent_out_valid(pkt_sent_out_valid),
    .tx_desc_valid     (tx_desc_valid),
    .tx_desc_addr      (tx_desc_addr),
    .tx_desc_len       (tx_desc_len),
    .recycle_desc      (recycle_desc),
    .recycle_valid     (recycle_valid)
  );

endmodule

/* tb/tb_model.svh */
// expected values and helpers, included inside tb_dma_controller

// receive address is the core, one zero bit, the slot base and offset 0x0a
function automatic logic [19:0] exp_rx_addr(input logic [3:0] core, input logic [6:0] base);
  return {core, 1'b0, base, 8'h0A};
endfunction

// transmit address puts the sending core above the message address
function automatic logic [19:0] exp_tx_addr(input logic [3:0] core, input logic [15:0] addr);
  return {core, addr};
endfunction

function automatic logic [31:0] next_rand();
  return $random(seed);
endfunction

task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
  if (got !== exp) begin
    $display("[FAIL] %0d ns: %s, got %0h expected %0h", $time, what, got, exp);
    $display("TEST FAILED");
    $fatal(1, "stopped at the first mismatch");
  end
endtask

task automatic abort_run(input string reason);
  $display("%0d ns: %s", $time, reason);
  $display("TEST FAILED");
  $fatal(1, "run aborted");
endtask

task automatic wait_rx_count(input int target);
  int n;
  n = 0;
  while (rx_count < target) begin
    @(negedge clk);
    n++;
    if (n > wait_limit) abort_run("timed out waiting for a receive descriptor");
  end
endtask

task automatic wait_tx_count(input int target);
  int n;
  n = 0;
  while (tx_count < target) begin
    @(negedge clk);
    n++;
    if (n > wait_limit) abort_run("timed out waiting for a transmit descriptor");
  end
endtask

// holds the message until accepted, then checks the issue one cycle later
task automatic accept_msg(input logic [1:0] exp_valid);
  int n;
  n = 0;
  @(posedge clk);
  while (!msg_ready) begin
    n++;
    if (n > wait_limit) abort_run("timed out waiting for msg_ready");
    @(posedge clk);
  end
  @(negedge clk);
  msg_valid = 1'b0;
  pkt_sent_out_valid = 2'b00;
  @(posedge clk);
  check_eq(32'(tx_desc_valid), 32'(exp_valid), "tx valid one cycle after accept");
  @(negedge clk);
endtask

/* tb/tb_dma_controller.sv */
module tb_dma_controller;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int wait_limit = 200;

  logic        clk;
  logic        rst;
  logic [1:0]  incoming_pkt_ready;
  logic [1:0]  pkt_sent_out_valid;
  logic [15:0] drop_list;
  logic        drop_list_valid;
  logic [15:0] max_pkt_len;
  logic        max_pkt_len_valid;
  logic [7:0]  inject_desc;
  logic        inject_desc_valid;
  logic        inject_desc_ready;
  logic [3:0]  slot_addr_wr_no;
  logic [6:0]  slot_addr_wr_data;
  logic        slot_addr_wr_valid;
  logic [1:0]  rx_desc_ready;
  logic [1:0]  rx_desc_valid;
  logic [19:0] rx_desc_addr;
  logic [15:0] rx_desc_len;
  logic [63:0] msg_data;
  logic [3:0]  msg_core_no;
  logic        msg_valid;
  logic        msg_ready;
  logic [1:0]  tx_desc_ready;
  logic [1:0]  tx_desc_valid;
  logic [19:0] tx_desc_addr;
  logic [15:0] tx_desc_len;

  integer      seed = 32'h948f;
  logic [6:0]  slot_tab [16];
  logic [15:0] cur_len = 16'd2048;
  logic [19:0] rx_exp_addr [$];
  logic        rx_exp_port [$];
  logic [19:0] tx_exp_addr [$];
  logic [15:0] tx_exp_len [$];
  logic        tx_exp_port [$];
  int          rx_count = 0;
  int          tx_count = 0;
  logic        cmp_port;
  logic [19:0] cmp_addr;
  logic [15:0] cmp_len;

  `include "tb_model.svh"

  dma_controller DUT (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic inject_slot(input logic [3:0] core, input logic [3:0] slot, input logic keep);
    int n;
    n = 0;
    @(negedge clk);
    inject_desc = {core, slot};
    inject_desc_valid = 1'b1;
    // dropped cores get no expected entry
    if (keep) rx_exp_addr.push_back(exp_rx_addr(core, slot_tab[slot]));
    @(posedge clk);
    while (!inject_desc_ready) begin
      n++;
      if (n > wait_limit) abort_run("timed out waiting for inject_desc_ready");
      @(posedge clk);
    end
    @(negedge clk);
    inject_desc_valid = 1'b0;
  endtask

  task automatic pulse_incoming(input logic [1:0] ports, input int cycles);
    @(negedge clk);
    incoming_pkt_ready = ports;
    repeat (cycles) @(negedge clk);
    incoming_pkt_ready = 2'b00;
  endtask

  task automatic write_drop_list(input logic [15:0] cores);
    @(negedge clk);
    drop_list = cores;
    drop_list_valid = 1'b1;
    @(negedge clk);
    drop_list_valid = 1'b0;
  endtask

  task automatic write_max_len(input logic [15:0] len);
    @(negedge clk);
    max_pkt_len = len;
    max_pkt_len_valid = 1'b1;
    @(negedge clk);
    max_pkt_len_valid = 1'b0;
    cur_len = len;
  endtask

  task automatic drive_msg(input logic [3:0] core, input logic port, input logic [3:0] slot,
                           input logic [15:0] addr, input logic [15:0] len);
    @(negedge clk);
    msg_core_no = core;
    msg_data = {16'h0000, addr, 4'h0, slot, 7'h00, port, len};
    msg_valid = 1'b1;
    if (len != 16'd0) begin
      tx_exp_port.push_back(port);
      tx_exp_addr.push_back(exp_tx_addr(core, addr));
      tx_exp_len.push_back(len);
    end
  endtask

  // compares every rx and tx valid against the expected queues
  always @(posedge clk) begin
    if (!rst && rx_desc_valid != 2'b00) begin
      if (rx_exp_addr.size() == 0 || rx_exp_port.size() == 0) begin
        abort_run("receive descriptor appeared with none expected");
      end else begin
        cmp_port = rx_exp_port.pop_front();
        cmp_addr = rx_exp_addr.pop_front();
        check_eq(32'(rx_desc_valid), 32'(2'b01 << cmp_port), "rx port");
        check_eq(32'(rx_desc_addr), 32'(cmp_addr), "rx address");
        check_eq(32'(rx_desc_len), 32'(cur_len), "rx length");
        rx_count++;
      end
    end
    if (!rst && tx_desc_valid != 2'b00) begin
      if (tx_exp_addr.size() == 0) begin
        abort_run("transmit descriptor appeared with none expected");
      end else begin
        cmp_port = tx_exp_port.pop_front();
        cmp_addr = tx_exp_addr.pop_front();
        cmp_len = tx_exp_len.pop_front();
        check_eq(32'(tx_desc_valid), 32'(2'b01 << cmp_port), "tx port");
        check_eq(32'(tx_desc_addr), 32'(cmp_addr), "tx address");
        check_eq(32'(tx_desc_len), 32'(cmp_len), "tx length");
        tx_count++;
      end
    end
  end

  initial begin
    logic [31:0] r;
    logic [3:0]  dc;
    logic [3:0]  ca;
    logic [3:0]  sa;
    logic [15:0] len;
    rst = 1'b1;
    incoming_pkt_ready = 2'b00;
    pkt_sent_out_valid = 2'b00;
    drop_list = '0;
    drop_list_valid = 1'b0;
    max_pkt_len = '0;
    max_pkt_len_valid = 1'b0;
    inject_desc = '0;
    inject_desc_valid = 1'b0;
    slot_addr_wr_no = '0;
    slot_addr_wr_data = '0;
    slot_addr_wr_valid = 1'b0;
    rx_desc_ready = 2'b11;
    msg_data = '0;
    msg_core_no = '0;
    msg_valid = 1'b0;
    tx_desc_ready = 2'b11;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // 1: idle state after reset
    check_eq(32'(rx_desc_valid), 0, "rx valid after reset");
    check_eq(32'(tx_desc_valid), 0, "tx valid after reset");
    check_eq(32'(msg_ready), 1, "msg_ready after reset");
    check_eq(32'(inject_desc_ready), 1, "inject_desc_ready after reset");

    // 2: slot table, injection, default then programmed length
    for (int i = 0; i < 16; i++) begin
      r = next_rand();
      slot_tab[i] = r[6:0];
      @(negedge clk);
      slot_addr_wr_no = 4'(i);
      slot_addr_wr_data = slot_tab[i];
      slot_addr_wr_valid = 1'b1;
    end
    @(negedge clk);
    slot_addr_wr_valid = 1'b0;
    for (int k = 0; k < 2; k++) begin
      for (int i = 0; i < 2; i++) begin
        r = next_rand();
        inject_slot(r[3:0], r[7:4], 1'b1);
        rx_exp_port.push_back(1'b0);
      end
      pulse_incoming(2'b01, 2);
      wait_rx_count(2 * k + 2);
      r = next_rand();
      if (k == 0) write_max_len({4'h0, r[11:0]} + 16'd1);
    end

    // 3: a dropped core is skipped, the next core gets through
    r = next_rand();
    dc = r[3:0];
    write_drop_list(16'd1 << dc);
    inject_slot(dc, r[7:4], 1'b0);
    inject_slot(dc, r[11:8], 1'b0);
    inject_slot(dc + 4'd1, r[15:12], 1'b1);
    rx_exp_port.push_back(1'b1);
    pulse_incoming(2'b10, 1);
    wait_rx_count(5);
    write_drop_list(16'h0000);

    // 4: both ports waiting, port 1 was served last so port 0 leads
    rx_desc_ready = 2'b00;
    for (int i = 0; i < 6; i++) begin
      r = next_rand();
      inject_slot(r[3:0], r[7:4], 1'b1);
      rx_exp_port.push_back(i[0]);
    end
    pulse_incoming(2'b11, 3);
    rx_desc_ready = 2'b11;
    wait_rx_count(11);

    // 5: issue timing, zero length, busy port holds off the next message
    r = next_rand();
    ca = r[3:0];
    sa = r[7:4];
    len = {4'h0, r[27:16]} + 16'd1;
    r = next_rand();
    drive_msg(ca, 1'b0, sa, r[15:0], len);
    accept_msg(2'b01);
    r = next_rand();
    drive_msg(r[3:0], 1'b1, r[7:4], r[31:16], 16'd0);
    accept_msg(2'b00);
    r = next_rand();
    drive_msg(r[3:0], 1'b0, r[7:4], r[31:16], {4'h0, r[19:8]} + 16'd1);
    repeat (4) begin
      @(posedge clk);
      check_eq(32'(msg_ready), 0, "msg_ready while port 0 busy");
    end

    // 6: the sent slot comes back as a free receive descriptor
    @(negedge clk);
    pkt_sent_out_valid = 2'b01;
    rx_exp_addr.push_back(exp_rx_addr(ca, slot_tab[sa]));
    accept_msg(2'b01);
    rx_exp_port.push_back(1'b1);
    pulse_incoming(2'b10, 1);
    wait_rx_count(12);
    r = next_rand();
    drive_msg(r[3:0], 1'b1, r[7:4], r[31:16], {4'h0, r[19:8]} + 16'd1);
    accept_msg(2'b10);
    wait_tx_count(3);

    repeat (10) @(negedge clk);
    if (rx_exp_addr.size() == 0 && rx_exp_port.size() == 0 && tx_exp_addr.size() == 0) begin
      $display("TEST PASSED");
      $finish;
    end else begin
      $display("expected descriptors never arrived");
      $display("TEST FAILED");
      $fatal(1, "descriptors left over");
    end
  end

endmodule

/* filelist.f */
+incdir+tb
logic/dma_pkg.sv
logic/rx_arb_if.sv
logic/desc_fifo.sv
logic/rx_desc_dispatch.sv
logic/rx_port_arbiter.sv
logic/tx_desc_issue.sv
logic/dma_controller.sv
tb/tb_dma_controller.sv

/* run.sh */
#!/bin/sh
# build the testbench with verilator and run it, the exit status is the result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_dma_controller -f filelist.f &&
./obj_dir/Vtb_dma_controller || exit 1
